/* hw/condCheck.sv */
// Combinational only; NV is executed like AL since the reserved space is not decoded elsewhere
module condCheck
	import isaPkg::*;
(
	input  cond_t  cond,
	input  flags_t flags,
	output logic   condPass
);

	logic signedLess; // N != V
	logic unsignedHigher; // C set and Z clear

	assign signedLess = flags.n ^ flags.v;
	assign unsignedHigher = flags.c & ~flags.z;

	always_comb begin
		case (cond)
			EQ: condPass = flags.z;
			NE: condPass = ~flags.z;
			CS: condPass = flags.c;
			CC: condPass = ~flags.c;
			MI: condPass = flags.n;
			PL: condPass = ~flags.n;
			VS: condPass = flags.v;
			VC: condPass = ~flags.v;
			HI: condPass = unsignedHigher;
			LS: condPass = ~unsignedHigher;
			GE: condPass = ~signedLess;
			LT: condPass = signedLess;
			GT: condPass = ~flags.z & ~signedLess; // Not equal and not less
			LE: condPass = flags.z | signedLess;
			default: condPass = 1'b1; // AL and NV
		endcase
	end

endmodule

/* hw/isaPkg.sv */
// ARM-style 32-bit encodings only; Thumb and coprocessor spaces are not described here
package isaPkg;

	typedef logic [31:0] instr_t; // One instruction word as fetched
	typedef logic [3:0]  regIdx_t; // R0..R15
	typedef logic [15:0] regList_t; // LDM mask, bit i loads Ri

	typedef enum logic [3:0] {
		EQ = 4'b0000, // Z set
		NE = 4'b0001,
		CS = 4'b0010, // Unsigned higher or same
		CC = 4'b0011,
		MI = 4'b0100,
		PL = 4'b0101,
		VS = 4'b0110,
		VC = 4'b0111,
		HI = 4'b1000, // Unsigned higher
		LS = 4'b1001,
		GE = 4'b1010, // Signed compares from here
		LT = 4'b1011,
		GT = 4'b1100,
		LE = 4'b1101,
		AL = 4'b1110,
		NV = 4'b1111 // Reserved, treated as always
	} cond_t;

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry / not borrow
		logic v; // Signed overflow
	} flags_t;

	// Data-processing view of an instruction word
	typedef struct packed {
		cond_t       cond;
		logic [2:0]  opClass; // [27:25], bit 25 is the immediate flag
		logic [3:0]  opcode;
		logic        s; // Flag update
		regIdx_t     rn;
		regIdx_t     rd;
		logic [11:0] operand2;
	} dpFields_t;

	localparam logic [3:0] OP_ADD = 4'b0100;
	localparam logic [3:0] OP_MOV = 4'b1101;

endpackage

/* hw/regListScanner.sv */
// nextReg/lastReg follow the stored list; startOffset is taken from the incoming list for the setup step
module regListScanner
	import isaPkg::*;
	import uopPkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           loadList,
	input  logic           advance,
	input  regList_t       regList,
	input  logic [1:0]     puBits,
	output regListStatus_t listStatus
);

	regList_t   pending; // Registers still to load
	regList_t   lowCleared; // pending without its lowest bit
	logic [4:0] popCount; // Set bits in incoming list
	logic [11:0] listBytes; // 4 * popCount

	assign lowCleared = pending & (pending - 16'd1);

	always_ff @(posedge clk) begin
		if (reset)
			pending <= '0;
		else if (loadList)
			pending <= regList; // New LDM accepted
		else if (advance)
			pending <= lowCleared; // One LDR issued
	end

	// Lowest set bit wins, scan from the top down
	always_comb begin
		listStatus.nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (pending[i])
				listStatus.nextReg = regIdx_t'(i);
		end
	end

	assign listStatus.lastReg = (pending != '0) && (lowCleared == '0);

	assign popCount = 5'($countones(regList));
	assign listBytes = {5'b0, popCount, 2'b00};

	always_comb begin
		case (puBits) // {P, U}
			2'b00: listStatus.startOffset = 12'd4 - listBytes; // Decrement after
			2'b01: listStatus.startOffset = 12'd0; // Increment after
			2'b10: listStatus.startOffset = -listBytes; // Decrement before
			default: listStatus.startOffset = 12'd4; // Increment before
		endcase
	end

endmodule

/* hw/uopExpander.sv */
// Zero-latency expander; the pipeline must hold instr while ctrl.uopStall is high
module uopExpander
	import isaPkg::*;
	import uopPkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  instr_t   instr,
	input  flags_t   flags,
	output instr_t   uopInstr,
	output uopCtrl_t ctrl
);

	logic           condPass;
	logic           loadList;
	logic           advance;
	regListStatus_t listStatus;

	condCheck condUnit (
		.cond     (cond_t'(instr[31:28])),
		.flags    (flags),
		.condPass (condPass)
	);

	regListScanner listScan (
		.clk        (clk),
		.reset      (reset),
		.loadList   (loadList),
		.advance    (advance),
		.regList    (instr[15:0]), // LDM register mask
		.puBits     (instr[24:23]), // Addressing mode
		.listStatus (listStatus)
	);

	uopSequencer sequencer (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.instr      (instr),
		.condPass   (condPass),
		.listStatus (listStatus),
		.loadList   (loadList),
		.advance    (advance),
		.uopInstr   (uopInstr),
		.ctrl       (ctrl)
	);

endmodule

/* hw/uopPkg.sv */
// Rz shares index 15 with PC in micro-op encodings; rzSel tells the register file which one is meant
package uopPkg;

	typedef enum logic [2:0] {
		ready, // Pass-through or first micro-op
		rsr, // Second RSR step
		multiply, // Accumulate step of MLA / long MLA
		ldmSetup, // Base computation into Rz
		ldmLoad // One LDR per listed register
	} uopState_t;

	typedef struct packed {
		logic       instrMux; // Take uopInstr instead of the fetched word
		logic       noFlagUpdate; // Block NZCV write
		logic       uopStall; // Hold fetch, more micro-ops follow
		logic       keepV; // Multiply leaves V alone
		logic       prevRsr; // Second step of a sequence
		logic       ldmForward; // Forward Rz between back-to-back loads
		logic       signExtend; // Imm12 is signed, not rotated
		logic [3:0] rzSel; // [3] RA1 input mux, [2:0] Rz on WA3 / RA2 / RA1
	} uopCtrl_t;

	typedef struct packed {
		isaPkg::regIdx_t nextReg; // Lowest pending register
		logic            lastReg; // Exactly one bit left
		logic [11:0]     startOffset; // Signed, from the incoming list
	} regListStatus_t;

	localparam isaPkg::regIdx_t RZ_INDEX = 4'd15;

	// rzSel codes
	localparam logic [3:0] RZ_NONE = 4'b0000;
	localparam logic [3:0] RZ_WA3  = 4'b1100; // Rz is the destination
	localparam logic [3:0] RZ_RA2  = 4'b0010; // Rz feeds operand two
	localparam logic [3:0] RZ_RA1  = 4'b0001; // Rz feeds Rn / base

endpackage

/* hw/uopSequencer.sv */
// instr must stay stable while uopStall is high; later micro-ops reuse its condition field unchanged
module uopSequencer
	import isaPkg::*;
	import uopPkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           stall,
	input  instr_t         instr,
	input  logic           condPass,
	input  regListStatus_t listStatus,
	output logic           loadList,
	output logic           advance,
	output instr_t         uopInstr,
	output uopCtrl_t       ctrl
);

	uopState_t state; // Registered step
	uopState_t nextState;
	uopState_t step; // Step issued this cycle
	dpFields_t dp; // Field view of instr
	logic      isRsr;
	logic      isMulAcc;
	logic      isLdm;
	logic      listEmpty; // LDM with no registers

	assign dp = instr;

	// Register-shifted operand two, but not the misc space (BX, MRS and friends)
	assign isRsr = (dp.opClass == 3'b000) && !instr[7] && instr[4]
		&& !((instr[24:23] == 2'b10) && !dp.s);
	assign isMulAcc = (instr[27:24] == 4'b0000) && (instr[7:4] == 4'b1001) && instr[21];
	assign isLdm = (dp.opClass == 3'b100) && instr[20]; // Load only, STM passes through
	assign listEmpty = (instr[15:0] == '0);

	// An accepted LDM issues its setup in the same cycle
	always_comb begin
		step = state;
		if ((state == ready) && condPass && isLdm)
			step = ldmSetup;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ready;
		else if (!stall)
			state <= nextState; // Frozen under back-pressure
	end

	assign loadList = (step == ldmSetup) && !stall;
	assign advance = (state == ldmLoad) && !stall;

	always_comb begin
		nextState = ready;
		uopInstr = instr; // Pass-through unless a step overrides
		ctrl = '0;
		case (step)
			ready: begin
				if (condPass && isRsr) begin
					// MOV Rz, Rm <shift> Rs with S clear
					uopInstr = {dp.cond, 3'b000, OP_MOV, 1'b0, 4'b0000, RZ_INDEX, dp.operand2};
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.uopStall = 1'b1;
					ctrl.rzSel = RZ_WA3;
					nextState = rsr;
				end else if (condPass && isMulAcc) begin
					if (!instr[23])
						uopInstr = {dp.cond, 8'b0000_0000, RZ_INDEX, 4'b0000, instr[11:0]}; // MUL Rz
					else
						uopInstr = {dp.cond, 5'b00001, instr[22], 2'b00, RZ_INDEX, RZ_INDEX,
							instr[11:0]}; // Plain long multiply, product held for accumulate
					ctrl.instrMux = 1'b1;
					ctrl.uopStall = 1'b1;
					ctrl.keepV = 1'b1;
					ctrl.rzSel = RZ_WA3;
					nextState = multiply;
				end
			end
			rsr: begin
				// Original op, operand two = Rz, LSL #0
				uopInstr = {instr[31:12], 8'b0000_0000, RZ_INDEX};
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rzSel = RZ_RA2;
				nextState = ready;
			end
			multiply: begin
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				if (!instr[23]) begin
					// ADD Rd, Rz, Rn keeps the original S
					uopInstr = {dp.cond, 3'b000, OP_ADD, dp.s, RZ_INDEX, instr[19:16],
						8'b0000_0000, instr[15:12]};
					ctrl.rzSel = RZ_RA1;
				end else begin
					// Rs/Rm slots carry RdLo/RdHi to the accumulator inputs
					uopInstr = {dp.cond, 5'b00001, instr[22], 1'b1, dp.s, instr[19:16],
						instr[15:12], instr[15:12], 4'b1001, instr[19:16]};
					ctrl.rzSel = RZ_NONE;
				end
				nextState = ready;
			end
			ldmSetup: begin
				// ADD Rz, Rn, #startOffset with signed imm12
				uopInstr = {dp.cond, 3'b001, OP_ADD, 1'b0, dp.rn, RZ_INDEX,
					listStatus.startOffset};
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.uopStall = !listEmpty; // Empty list ends here
				ctrl.signExtend = 1'b1;
				ctrl.rzSel = RZ_WA3;
				nextState = listEmpty ? ready : ldmLoad;
			end
			ldmLoad: begin
				// LDR nextReg, [Rz], #4 (post-indexed, up)
				uopInstr = {dp.cond, 3'b010, 5'b01001, RZ_INDEX, listStatus.nextReg, 12'd4};
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.uopStall = !listStatus.lastReg;
				ctrl.ldmForward = 1'b1;
				ctrl.rzSel = RZ_RA1;
				nextState = listStatus.lastReg ? ready : ldmLoad;
			end
			default: nextState = ready;
		endcase
	end

endmodule

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -f sources.f --top-module uopExpanderTb \
	-Mdir obj_dir -o uopExpanderSim

./obj_dir/uopExpanderSim > sim.log
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "Simulation result: pass"
	exit 0
fi
echo "Simulation result: fail"
exit 1

/* sources.f */
hw/isaPkg.sv
hw/uopPkg.sv
hw/condCheck.sv
hw/regListScanner.sv
hw/uopSequencer.sv
hw/uopExpander.sv
testbench/uopExpanderTb.sv

/* testbench/uopExpanderTb.sv */
// Run from the project root so the golden path resolves; vectors are applied one per clock after reset
module uopExpanderTb
	import isaPkg::*;
	import uopPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    RESET_CYCLES   = 8;
	localparam int    TIMEOUT_MARGIN = 50; // Slack cycles past the last vector
	localparam string GOLDEN_PATH    = "testbench/uopGolden.txt";

	logic     clk = 1'b0;
	logic     reset;
	logic     stall;
	instr_t   instr;
	flags_t   flags;
	instr_t   uopInstr;
	uopCtrl_t ctrl;

	// Golden vectors, one entry per cycle
	instr_t   instrVec[$];
	flags_t   flagsVec[$];
	logic     stallVec[$];
	instr_t   expInstrVec[$];
	uopCtrl_t expCtrlVec[$];

	int instrErrors;
	int ctrlErrors;
	int otherErrors;
	int cycleCount;
	int cycleLimit = RESET_CYCLES + TIMEOUT_MARGIN; // Raised once the vectors are known

	uopExpander UUT (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.instr    (instr),
		.flags    (flags),
		.uopInstr (uopInstr),
		.ctrl     (ctrl)
	);

	always #4 clk = ~clk; // 8 ns period

	// Watchdog
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic loadGolden();
		int          fd;
		int          count;
		int          lineNo;
		string       line;
		logic [31:0] vInstr;
		logic [3:0]  vFlags;
		logic        vStall;
		logic [31:0] vUop;
		logic [10:0] vCtrl;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open golden file %s", GOLDEN_PATH);
			otherErrors++;
			return;
		end
		lineNo = 0;
		while (!$feof(fd)) begin
			count = $fgets(line, fd);
			lineNo++;
			if (count == 0 || line.len() < 2 || line.getc(0) == "/")
				continue; // Blank or comment line
			count = $sscanf(line, "%h %h %h %h %h", vInstr, vFlags, vStall, vUop, vCtrl);
			if (count != 5) begin
				$display("Golden file line %0d could not be parsed", lineNo);
				otherErrors++;
			end else begin
				instrVec.push_back(vInstr);
				flagsVec.push_back(flags_t'(vFlags));
				stallVec.push_back(vStall);
				expInstrVec.push_back(vUop);
				expCtrlVec.push_back(uopCtrl_t'(vCtrl));
			end
		end
		$fclose(fd);
		if (instrVec.size() == 0) begin
			$display("Golden file holds no vectors");
			otherErrors++;
		end
	endtask

	task automatic checkInstr(int vecIdx, string name, instr_t actual, instr_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns vector %0d %s: got %08h expected %08h",
				$time, vecIdx, name, actual, expected);
			instrErrors++;
		end
	endtask

	task automatic checkCtrl(int vecIdx, string name, uopCtrl_t actual, uopCtrl_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns vector %0d %s: got %03h expected %03h",
				$time, vecIdx, name, actual, expected);
			ctrlErrors++;
		end
	endtask

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		instr = '0;
		flags = '0;
		instrErrors = 0;
		ctrlErrors = 0;
		otherErrors = 0;
		cycleCount = 0;
		loadGolden();
		cycleLimit = RESET_CYCLES + instrVec.size() + TIMEOUT_MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (instrVec[i]) begin
			instr = instrVec[i]; // Driven 1 ns after the edge
			flags = flagsVec[i];
			stall = stallVec[i];
			#6; // Sample 1 ns before the next edge
			checkInstr(i, "uopInstr", uopInstr, expInstrVec[i]);
			checkCtrl(i, "ctrl", ctrl, expCtrlVec[i]);
			@(posedge clk);
			#1;
		end
		$display("Errors: uopInstr %0d, ctrl %0d, other %0d",
			instrErrors, ctrlErrors, otherErrors);
		if (instrErrors + ctrlErrors + otherErrors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* testbench/uopGolden.txt */
// Columns: instr flags(NZCV) stall expUopInstr expCtrl, all hex, one line per cycle
// ctrl bits: instrMux noFlagUpdate uopStall keepV prevRsr ldmForward signExtend rzSel[3:0]
E0821003 0 0 E0821003 000
// RSR ADD R1,R2,R3,LSL R4
E0821413 0 0 E1A0F413 70C
E0821413 0 0 E082100F 442
E0821003 0 0 E0821003 000
// MLAS R1,R2,R3,R4 then UMLAL R5,R6,R2,R3
E0314392 0 0 E00F0392 58C
E0314392 0 0 E09F1004 441
E0A65392 0 0 E08FF392 58C
E0A65392 0 0 E0A65596 440
// LDMIA R0,{R1,R3,R4}
E890001A 0 0 E280F000 71C
E890001A 0 0 E49F1004 721
E890001A 0 0 E49F3004 721
E890001A 0 0 E49F4004 621
// LDMIB R3,{R5} and LDMDA R4,{R2,R9}
E9930020 0 0 E283F004 71C
E9930020 0 0 E49F5004 621
E8140204 0 0 E284FFFC 71C
E8140204 0 0 E49F2004 721
E8140204 0 0 E49F9004 621
// Failing conditions pass through, GT passes with C only
00821413 0 0 00821413 000
10314392 4 0 10314392 000
A890001A 8 0 A890001A 000
C0821413 2 0 C1A0F413 70C
C0821413 2 0 C082100F 442
// Back-pressure inside RSR and LDMDB R2,{R0,R7}
E0821413 0 1 E1A0F413 70C
E0821413 0 0 E1A0F413 70C
E0821413 0 1 E082100F 442
E0821413 0 0 E082100F 442
E9120081 0 1 E282FFF8 71C
E9120081 0 0 E282FFF8 71C
E9120081 0 1 E49F0004 721
E9120081 0 0 E49F0004 721
E9120081 0 0 E49F7004 621
E0821003 0 0 E0821003 000
